/* design/rr_pkg.sv */
package rr_pkg;

   // ----------------------------------------------------------
   // axi-lite bus widths
   // ----------------------------------------------------------
   localparam int AXIL_ADDR_WIDTH = 32;
   localparam int AXIL_DATA_WIDTH = 32;
   localparam int AXIL_STRB_WIDTH = AXIL_DATA_WIDTH / 8;

   // ----------------------------------------------------------
   // record format
   // ----------------------------------------------------------
   // aw field is awaddr only
   localparam int AXIL_RR_AW_WIDTH = AXIL_ADDR_WIDTH;
   // w field is {wstrb, wdata}
   localparam int AXIL_RR_W_WIDTH = AXIL_DATA_WIDTH + AXIL_STRB_WIDTH;
   localparam int AXIL_RR_AR_WIDTH = AXIL_ADDR_WIDTH;
   localparam int AXIL_RR_MSTR_WIDTH = AXIL_RR_AW_WIDTH + AXIL_RR_W_WIDTH + AXIL_RR_AR_WIDTH;
   // bit 0 hasAW, bit 1 hasW, bit 2 hasAR
   localparam int AXIL_RR_HDR_WIDTH = 3;
   localparam int RR_OFFSET_WIDTH = $clog2(AXIL_RR_MSTR_WIDTH);

   // ----------------------------------------------------------
   // log fifo and register file
   // ----------------------------------------------------------
   localparam int RR_LOG_DEPTH = 16;
   localparam int RR_DROP_WIDTH = 16;
   // registers addressed by awaddr/araddr bits 5..2
   localparam int REG_COUNT = 16;

endpackage

/* design/axil_record_mstr.sv */
`timescale 1ns/100ps

module axil_record_mstr import rr_pkg::*; (
   input  logic                          clk,
   input  logic                          sync_rst_n,
   // upstream master side
   input  logic [AXIL_ADDR_WIDTH-1:0]    s_awaddr,
   input  logic                          s_awvalid,
   output logic                          s_awready,
   input  logic [AXIL_DATA_WIDTH-1:0]    s_wdata,
   input  logic [AXIL_STRB_WIDTH-1:0]    s_wstrb,
   input  logic                          s_wvalid,
   output logic                          s_wready,
   output logic [1:0]                    s_bresp,
   output logic                          s_bvalid,
   input  logic                          s_bready,
   input  logic [AXIL_ADDR_WIDTH-1:0]    s_araddr,
   input  logic                          s_arvalid,
   output logic                          s_arready,
   output logic [AXIL_DATA_WIDTH-1:0]    s_rdata,
   output logic [1:0]                    s_rresp,
   output logic                          s_rvalid,
   input  logic                          s_rready,
   // downstream slave side
   output logic [AXIL_ADDR_WIDTH-1:0]    m_awaddr,
   output logic                          m_awvalid,
   input  logic                          m_awready,
   output logic [AXIL_DATA_WIDTH-1:0]    m_wdata,
   output logic [AXIL_STRB_WIDTH-1:0]    m_wstrb,
   output logic                          m_wvalid,
   input  logic                          m_wready,
   input  logic [1:0]                    m_bresp,
   input  logic                          m_bvalid,
   output logic                          m_bready,
   output logic [AXIL_ADDR_WIDTH-1:0]    m_araddr,
   output logic                          m_arvalid,
   input  logic                          m_arready,
   input  logic [AXIL_DATA_WIDTH-1:0]    m_rdata,
   input  logic [1:0]                    m_rresp,
   input  logic                          m_rvalid,
   output logic                          m_rready,
   // record stream to the log fifo
   output logic                          rec_valid,
   output logic [AXIL_RR_HDR_WIDTH-1:0]  rec_hdr,
   output logic [AXIL_RR_MSTR_WIDTH-1:0] rec_data
);

   // ----------------------------------------------------------
   // zero-latency pass-through of all five channels
   // ----------------------------------------------------------
   assign m_awaddr  = s_awaddr;
   assign m_awvalid = s_awvalid;
   assign s_awready = m_awready;

   assign m_wdata   = s_wdata;
   assign m_wstrb   = s_wstrb;
   assign m_wvalid  = s_wvalid;
   assign s_wready  = m_wready;

   assign s_bresp   = m_bresp;
   assign s_bvalid  = m_bvalid;
   assign m_bready  = s_bready;

   assign m_araddr  = s_araddr;
   assign m_arvalid = s_arvalid;
   assign s_arready = m_arready;

   assign s_rdata   = m_rdata;
   assign s_rresp   = m_rresp;
   assign s_rvalid  = m_rvalid;
   assign m_rready  = s_rready;

   // ----------------------------------------------------------
   // stage 1: capture completed request handshakes
   // ----------------------------------------------------------
   logic [AXIL_RR_HDR_WIDTH-1:0] s1_hdr;
   logic [AXIL_RR_AW_WIDTH-1:0]  s1_aw;
   logic [AXIL_RR_W_WIDTH-1:0]   s1_w;
   logic [AXIL_RR_AR_WIDTH-1:0]  s1_ar;

   // a stalled request is seen once, on the cycle it transfers
   always_ff @(posedge clk) begin
      if (!sync_rst_n) begin
         s1_hdr <= '0;
      end else begin
         s1_hdr <= {s_arvalid & s_arready, s_wvalid & s_wready, s_awvalid & s_awready};
      end
      if (s_awvalid && s_awready)
         s1_aw <= s_awaddr;
      if (s_wvalid && s_wready)
         s1_w <= {s_wstrb, s_wdata};
      if (s_arvalid && s_arready)
         s1_ar <= s_araddr;
   end

   // ----------------------------------------------------------
   // stage 2: field offsets inside the packed word
   // ----------------------------------------------------------
   logic [AXIL_RR_HDR_WIDTH-1:0] s2_hdr;
   logic [AXIL_RR_AW_WIDTH-1:0]  s2_aw;
   logic [AXIL_RR_W_WIDTH-1:0]   s2_w;
   logic [AXIL_RR_AR_WIDTH-1:0]  s2_ar;
   logic [RR_OFFSET_WIDTH-1:0]   s2_off_w;
   logic [RR_OFFSET_WIDTH-1:0]   s2_off_ar;

   always_ff @(posedge clk) begin
      if (!sync_rst_n) begin
         s2_hdr <= '0;
      end else begin
         s2_hdr <= s1_hdr;
      end
      s2_aw <= s1_aw;
      s2_w  <= s1_w;
      s2_ar <= s1_ar;
      // aw always sits at bit 0, w follows aw, ar follows both
      s2_off_w  <= s1_hdr[0] ? RR_OFFSET_WIDTH'(AXIL_RR_AW_WIDTH) : '0;
      s2_off_ar <= (s1_hdr[0] ? RR_OFFSET_WIDTH'(AXIL_RR_AW_WIDTH) : '0) +
                   (s1_hdr[1] ? RR_OFFSET_WIDTH'(AXIL_RR_W_WIDTH) : '0);
   end

   // ----------------------------------------------------------
   // stage 3: pack present fields into a zeroed word
   // ----------------------------------------------------------
   logic [AXIL_RR_MSTR_WIDTH-1:0] pack_word;

   always_comb begin
      pack_word = '0;
      if (s2_hdr[0])
         pack_word[AXIL_RR_AW_WIDTH-1:0] = s2_aw;
      if (s2_hdr[1])
         pack_word[s2_off_w +: AXIL_RR_W_WIDTH] = s2_w;
      if (s2_hdr[2])
         pack_word[s2_off_ar +: AXIL_RR_AR_WIDTH] = s2_ar;
   end

   always_ff @(posedge clk) begin
      if (!sync_rst_n) begin
         rec_valid <= 1'b0;
      end else begin
         rec_valid <= |s2_hdr;
      end
      rec_hdr  <= s2_hdr;
      rec_data <= pack_word;
   end

endmodule

/* design/rr_log_fifo.sv */
`timescale 1ns/100ps

module rr_log_fifo import rr_pkg::*; (
   input  logic                          clk,
   input  logic                          sync_rst_n,
   // records from the recorder, no back-pressure
   input  logic                          rec_valid,
   input  logic [AXIL_RR_HDR_WIDTH-1:0]  rec_hdr,
   input  logic [AXIL_RR_MSTR_WIDTH-1:0] rec_data,
   // host side
   input  logic                          log_pop,
   output logic                          log_valid,
   output logic [AXIL_RR_HDR_WIDTH-1:0]  log_hdr,
   output logic [AXIL_RR_MSTR_WIDTH-1:0] log_data,
   output logic [RR_DROP_WIDTH-1:0]      drop_count
);

   logic [AXIL_RR_HDR_WIDTH-1:0]  hdr_mem  [RR_LOG_DEPTH];
   logic [AXIL_RR_MSTR_WIDTH-1:0] data_mem [RR_LOG_DEPTH];

   logic [$clog2(RR_LOG_DEPTH)-1:0] wr_ptr;
   logic [$clog2(RR_LOG_DEPTH)-1:0] rd_ptr;
   logic [$clog2(RR_LOG_DEPTH):0]   count;

   logic full;
   logic pop;
   logic push;
   logic drop;

   assign full = (count == RR_LOG_DEPTH);
   assign pop  = log_pop & log_valid;
   // a pop on the same edge frees the slot for the incoming record
   assign push = rec_valid & (~full | pop);
   assign drop = rec_valid & full & ~pop;

   // ----------------------------------------------------------
   // storage, show-ahead read
   // ----------------------------------------------------------
   always_ff @(posedge clk) begin
      if (push) begin
         hdr_mem[wr_ptr]  <= rec_hdr;
         data_mem[wr_ptr] <= rec_data;
      end
   end

   assign log_valid = (count != '0);
   assign log_hdr   = hdr_mem[rd_ptr];
   assign log_data  = data_mem[rd_ptr];

   // ----------------------------------------------------------
   // pointers and occupancy
   // ----------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!sync_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= (wr_ptr == RR_LOG_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == RR_LOG_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // drop counter, sticks at all ones
   always_ff @(posedge clk) begin
      if (!sync_rst_n) begin
         drop_count <= '0;
      end else if (drop && (drop_count != '1)) begin
         drop_count <= drop_count + 1'b1;
      end
   end

endmodule

/* design/axil_reg_slave.sv */
`timescale 1ns/100ps

module axil_reg_slave import rr_pkg::*; (
   input  logic                       clk,
   input  logic                       sync_rst_n,
   // write address and data
   input  logic [AXIL_ADDR_WIDTH-1:0] awaddr,
   input  logic                       awvalid,
   output logic                       awready,
   input  logic [AXIL_DATA_WIDTH-1:0] wdata,
   input  logic [AXIL_STRB_WIDTH-1:0] wstrb,
   input  logic                       wvalid,
   output logic                       wready,
   // write response
   output logic [1:0]                 bresp,
   output logic                       bvalid,
   input  logic                       bready,
   // read address
   input  logic [AXIL_ADDR_WIDTH-1:0] araddr,
   input  logic                       arvalid,
   output logic                       arready,
   // read data
   output logic [AXIL_DATA_WIDTH-1:0] rdata,
   output logic [1:0]                 rresp,
   output logic                       rvalid,
   input  logic                       rready
);

   logic [AXIL_DATA_WIDTH-1:0] regs [REG_COUNT];

   logic wr_en;
   logic rd_en;
   logic [$clog2(REG_COUNT)-1:0] wr_idx;
   logic [$clog2(REG_COUNT)-1:0] rd_idx;

   // word index from the address, byte offset bits ignored
   assign wr_idx = awaddr[2 +: $clog2(REG_COUNT)];
   assign rd_idx = araddr[2 +: $clog2(REG_COUNT)];

   // ----------------------------------------------------------
   // write path
   // ----------------------------------------------------------
   // address and data taken together, only with no b pending
   assign awready = awvalid & wvalid & ~bvalid;
   assign wready  = awready;
   assign wr_en   = awready;

   always_ff @(posedge clk) begin
      if (!sync_rst_n) begin
         for (int i = 0; i < REG_COUNT; i++)
            regs[i] <= '0;
      end else if (wr_en) begin
         for (int b = 0; b < AXIL_STRB_WIDTH; b++) begin
            if (wstrb[b])
               regs[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!sync_rst_n) begin
         bvalid <= 1'b0;
      end else if (wr_en) begin
         bvalid <= 1'b1;
      end else if (bready) begin
         bvalid <= 1'b0;
      end
   end

   // always OKAY
   assign bresp = 2'b00;

   // ----------------------------------------------------------
   // read path
   // ----------------------------------------------------------
   assign arready = ~rvalid;
   assign rd_en   = arvalid & arready;

   always_ff @(posedge clk) begin
      if (!sync_rst_n) begin
         rvalid <= 1'b0;
      end else if (rd_en) begin
         rvalid <= 1'b1;
      end else if (rready) begin
         rvalid <= 1'b0;
      end
   end

   // held stable while rvalid waits for rready
   always_ff @(posedge clk) begin
      if (rd_en)
         rdata <= regs[rd_idx];
   end

   assign rresp = 2'b00;

endmodule

/* design/rr_subsys_top.sv */
`timescale 1ns/100ps

module rr_subsys_top import rr_pkg::*; (
   input  logic                          clk,
   input  logic                          sync_rst_n,
   // upstream axi-lite
   input  logic [AXIL_ADDR_WIDTH-1:0]    s_awaddr,
   input  logic                          s_awvalid,
   output logic                          s_awready,
   input  logic [AXIL_DATA_WIDTH-1:0]    s_wdata,
   input  logic [AXIL_STRB_WIDTH-1:0]    s_wstrb,
   input  logic                          s_wvalid,
   output logic                          s_wready,
   output logic [1:0]                    s_bresp,
   output logic                          s_bvalid,
   input  logic                          s_bready,
   input  logic [AXIL_ADDR_WIDTH-1:0]    s_araddr,
   input  logic                          s_arvalid,
   output logic                          s_arready,
   output logic [AXIL_DATA_WIDTH-1:0]    s_rdata,
   output logic [1:0]                    s_rresp,
   output logic                          s_rvalid,
   input  logic                          s_rready,
   // host log port
   input  logic                          log_pop,
   output logic                          log_valid,
   output logic [AXIL_RR_HDR_WIDTH-1:0]  log_hdr,
   output logic [AXIL_RR_MSTR_WIDTH-1:0] log_data,
   output logic [RR_DROP_WIDTH-1:0]      drop_count
);

   // ----------------------------------------------------------
   // recorder to register slave
   // ----------------------------------------------------------
   logic [AXIL_ADDR_WIDTH-1:0] m_awaddr;
   logic                       m_awvalid;
   logic                       m_awready;
   logic [AXIL_DATA_WIDTH-1:0] m_wdata;
   logic [AXIL_STRB_WIDTH-1:0] m_wstrb;
   logic                       m_wvalid;
   logic                       m_wready;
   logic [1:0]                 m_bresp;
   logic                       m_bvalid;
   logic                       m_bready;
   logic [AXIL_ADDR_WIDTH-1:0] m_araddr;
   logic                       m_arvalid;
   logic                       m_arready;
   logic [AXIL_DATA_WIDTH-1:0] m_rdata;
   logic [1:0]                 m_rresp;
   logic                       m_rvalid;
   logic                       m_rready;

   // record stream
   logic                          rec_valid;
   logic [AXIL_RR_HDR_WIDTH-1:0]  rec_hdr;
   logic [AXIL_RR_MSTR_WIDTH-1:0] rec_data;

   axil_record_mstr u_record (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .s_awaddr   (s_awaddr),
      .s_awvalid  (s_awvalid),
      .s_awready  (s_awready),
      .s_wdata    (s_wdata),
      .s_wstrb    (s_wstrb),
      .s_wvalid   (s_wvalid),
      .s_wready   (s_wready),
      .s_bresp    (s_bresp),
      .s_bvalid   (s_bvalid),
      .s_bready   (s_bready),
      .s_araddr   (s_araddr),
      .s_arvalid  (s_arvalid),
      .s_arready  (s_arready),
      .s_rdata    (s_rdata),
      .s_rresp    (s_rresp),
      .s_rvalid   (s_rvalid),
      .s_rready   (s_rready),
      .m_awaddr   (m_awaddr),
      .m_awvalid  (m_awvalid),
      .m_awready  (m_awready),
      .m_wdata    (m_wdata),
      .m_wstrb    (m_wstrb),
      .m_wvalid   (m_wvalid),
      .m_wready   (m_wready),
      .m_bresp    (m_bresp),
      .m_bvalid   (m_bvalid),
      .m_bready   (m_bready),
      .m_araddr   (m_araddr),
      .m_arvalid  (m_arvalid),
      .m_arready  (m_arready),
      .m_rdata    (m_rdata),
      .m_rresp    (m_rresp),
      .m_rvalid   (m_rvalid),
      .m_rready   (m_rready),
      .rec_valid  (rec_valid),
      .rec_hdr    (rec_hdr),
      .rec_data   (rec_data)
   );

   rr_log_fifo u_log_fifo (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .rec_valid  (rec_valid),
      .rec_hdr    (rec_hdr),
      .rec_data   (rec_data),
      .log_pop    (log_pop),
      .log_valid  (log_valid),
      .log_hdr    (log_hdr),
      .log_data   (log_data),
      .drop_count (drop_count)
   );

   axil_reg_slave u_reg_slave (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .awaddr     (m_awaddr),
      .awvalid    (m_awvalid),
      .awready    (m_awready),
      .wdata      (m_wdata),
      .wstrb      (m_wstrb),
      .wvalid     (m_wvalid),
      .wready     (m_wready),
      .bresp      (m_bresp),
      .bvalid     (m_bvalid),
      .bready     (m_bready),
      .araddr     (m_araddr),
      .arvalid    (m_arvalid),
      .arready    (m_arready),
      .rdata      (m_rdata),
      .rresp      (m_rresp),
      .rvalid     (m_rvalid),
      .rready     (m_rready)
   );

endmodule

/* testbench/tb_top.sv */
`timescale 1ns/100ps

module tb_top import rr_pkg::*; ();

   localparam int CLK_PERIOD = 8;
   localparam int WR_MIXED = 120;
   localparam int WR_STALL = 12;
   localparam int WR_FLOOD = 40;
   // every phase issues as many reads as writes
   localparam int TX_COUNT = 2 * (WR_MIXED + WR_STALL + WR_FLOOD);
   // handshake at edge k reaches the log fifo at edge k+3
   localparam int REC_LATENCY = 3;
   localparam int REG_IDX_WIDTH = $clog2(REG_COUNT);

   logic clk;
   logic sync_rst_n;
   logic [AXIL_ADDR_WIDTH-1:0] s_awaddr;
   logic s_awvalid;
   logic s_awready;
   logic [AXIL_DATA_WIDTH-1:0] s_wdata;
   logic [AXIL_STRB_WIDTH-1:0] s_wstrb;
   logic s_wvalid;
   logic s_wready;
   logic [1:0] s_bresp;
   logic s_bvalid;
   logic s_bready;
   logic [AXIL_ADDR_WIDTH-1:0] s_araddr;
   logic s_arvalid;
   logic s_arready;
   logic [AXIL_DATA_WIDTH-1:0] s_rdata;
   logic [1:0] s_rresp;
   logic s_rvalid;
   logic s_rready;
   logic log_pop;
   logic log_valid;
   logic [AXIL_RR_HDR_WIDTH-1:0] log_hdr;
   logic [AXIL_RR_MSTR_WIDTH-1:0] log_data;
   logic [RR_DROP_WIDTH-1:0] drop_count;

   rr_subsys_top DUT (.*);

   // ----------------------------------------------------------
   // model state and stimulus controls
   // ----------------------------------------------------------
   int errors;
   int wr_target, rd_target;
   int aw_sent, w_sent, ar_sent;
   int wr_acc, rd_acc, b_pend;
   int b_count, r_count, pop_count, model_drops;
   int issue_pct, bready_pct, rready_pct, pop_pct;
   logic aw_fire, w_fire, ar_fire;

   logic [AXIL_DATA_WIDTH-1:0] model_regs [REG_COUNT];
   logic [AXIL_DATA_WIDTH-1:0] exp_rdata [$];
   logic [AXIL_RR_HDR_WIDTH-1:0] dly_hdr [$];
   logic [AXIL_RR_MSTR_WIDTH-1:0] dly_data [$];
   logic [AXIL_RR_HDR_WIDTH-1:0] fifo_hdr [$];
   logic [AXIL_RR_MSTR_WIDTH-1:0] fifo_data [$];

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic check_equal(input logic [127:0] actual, input logic [127:0] expected,
                              input string what);
      if (actual !== expected) begin
         errors++;
         $display("[FAIL] %0t ns: %s got %0h expected %0h", $time, what, actual, expected);
      end
   endtask

   // present fields end to end from bit 0, AW then W then AR
   function automatic logic [AXIL_RR_MSTR_WIDTH-1:0] pack_record(
      input logic [AXIL_RR_HDR_WIDTH-1:0] hdr, input logic [AXIL_RR_AW_WIDTH-1:0] aw,
      input logic [AXIL_RR_W_WIDTH-1:0] w, input logic [AXIL_RR_AR_WIDTH-1:0] ar);
      logic [AXIL_RR_MSTR_WIDTH-1:0] word;
      int pos;
      word = '0;
      pos = 0;
      if (hdr[0]) begin
         word = word | (AXIL_RR_MSTR_WIDTH'(aw) << pos);
         pos = pos + AXIL_RR_AW_WIDTH;
      end
      if (hdr[1]) begin
         word = word | (AXIL_RR_MSTR_WIDTH'(w) << pos);
         pos = pos + AXIL_RR_W_WIDTH;
      end
      if (hdr[2])
         word = word | (AXIL_RR_MSTR_WIDTH'(ar) << pos);
      return word;
   endfunction

   function automatic logic [AXIL_ADDR_WIDTH-1:0] rand_addr();
      return AXIL_ADDR_WIDTH'($urandom_range(REG_COUNT - 1, 0)) << 2;
   endfunction

   function automatic logic pipeline_busy();
      foreach (dly_hdr[i])
         if (dly_hdr[i] != '0)
            return 1'b1;
      return 1'b0;
   endfunction

   // ----------------------------------------------------------
   // observe at the falling edge, drive at the rising edge
   // ----------------------------------------------------------
   task automatic observe_cycle();
      logic b_fire;
      logic r_fire;
      logic pop_now;
      logic full_now;
      logic [AXIL_RR_HDR_WIDTH-1:0] hdr;
      logic [AXIL_RR_HDR_WIDTH-1:0] old_hdr;
      logic [AXIL_RR_MSTR_WIDTH-1:0] old_data;
      logic [REG_IDX_WIDTH-1:0] idx;
      // state left by earlier edges
      check_equal(log_valid, fifo_hdr.size() != 0, "log_valid");
      check_equal(drop_count, model_drops, "drop_count");
      // ready and valid levels from the outstanding responses
      check_equal(s_awready, s_awvalid & s_wvalid & (b_pend == 0), "awready");
      check_equal(s_wready, s_awvalid & s_wvalid & (b_pend == 0), "wready");
      check_equal(s_arready, exp_rdata.size() == 0, "arready");
      check_equal(s_bvalid, b_pend != 0, "bvalid");
      check_equal(s_rvalid, exp_rdata.size() != 0, "rvalid");
      aw_fire = s_awvalid & s_awready;
      w_fire = s_wvalid & s_wready;
      ar_fire = s_arvalid & s_arready;
      b_fire = s_bvalid & s_bready;
      r_fire = s_rvalid & s_rready;
      if (b_fire) begin
         b_count++;
         check_equal(s_bresp, 2'b00, "bresp");
         if (b_pend == 0) begin
            errors++;
            $display("error at %0t ns: write response with no write outstanding", $time);
         end else begin
            b_pend--;
         end
      end
      if (r_fire) begin
         r_count++;
         check_equal(s_rresp, 2'b00, "rresp");
         if (exp_rdata.size() == 0) begin
            errors++;
            $display("error at %0t ns: read data with no read outstanding", $time);
         end else begin
            check_equal(s_rdata, exp_rdata.pop_front(), "rdata");
         end
      end
      // read sees the register before a write on the same edge
      if (ar_fire) begin
         idx = s_araddr[2 +: REG_IDX_WIDTH];
         exp_rdata.push_back(model_regs[idx]);
         rd_acc++;
      end
      if (aw_fire && w_fire) begin
         idx = s_awaddr[2 +: REG_IDX_WIDTH];
         for (int b = 0; b < AXIL_STRB_WIDTH; b++)
            if (s_wstrb[b])
               model_regs[idx][8*b +: 8] = s_wdata[8*b +: 8];
         wr_acc++;
         b_pend++;
      end
      hdr = {ar_fire, w_fire, aw_fire};
      dly_hdr.push_back(hdr);
      dly_data.push_back(pack_record(hdr, s_awaddr, {s_wstrb, s_wdata}, s_araddr));
      // log fifo, pop and push on the same edge
      full_now = (fifo_hdr.size() == RR_LOG_DEPTH);
      pop_now = log_pop && (fifo_hdr.size() != 0);
      if (pop_now) begin
         check_equal(log_hdr, fifo_hdr.pop_front(), "log_hdr");
         check_equal(log_data, fifo_data.pop_front(), "log_data");
         pop_count++;
      end
      if (dly_hdr.size() > REC_LATENCY) begin
         old_hdr = dly_hdr.pop_front();
         old_data = dly_data.pop_front();
         if (old_hdr != '0) begin
            if (!full_now || pop_now) begin
               fifo_hdr.push_back(old_hdr);
               fifo_data.push_back(old_data);
            end else if (model_drops < (1 << RR_DROP_WIDTH) - 1) begin
               model_drops++;
            end
         end
      end
   endtask

   task automatic drive_inputs();
      // a valid is held until its handshake
      if (!s_awvalid || aw_fire) begin
         if (aw_sent < wr_target && $urandom_range(99, 0) < issue_pct) begin
            s_awaddr <= rand_addr();
            s_awvalid <= 1'b1;
            aw_sent++;
         end else begin
            s_awvalid <= 1'b0;
         end
      end
      if (!s_wvalid || w_fire) begin
         if (w_sent < wr_target && $urandom_range(99, 0) < issue_pct) begin
            s_wdata <= $urandom();
            s_wstrb <= $urandom_range(15, 0);
            s_wvalid <= 1'b1;
            w_sent++;
         end else begin
            s_wvalid <= 1'b0;
         end
      end
      if (!s_arvalid || ar_fire) begin
         if (ar_sent < rd_target && $urandom_range(99, 0) < issue_pct) begin
            s_araddr <= rand_addr();
            s_arvalid <= 1'b1;
            ar_sent++;
         end else begin
            s_arvalid <= 1'b0;
         end
      end
      s_bready <= ($urandom_range(99, 0) < bready_pct);
      s_rready <= ($urandom_range(99, 0) < rready_pct);
      log_pop <= ($urandom_range(99, 0) < pop_pct);
   endtask

   task automatic step();
      @(negedge clk);
      observe_cycle();
      @(posedge clk);
      drive_inputs();
   endtask

   task automatic set_mode(input int issue, input int bready, input int rready, input int pop);
      issue_pct = issue;
      bready_pct = bready;
      rready_pct = rready;
      pop_pct = pop;
   endtask

   task automatic run_traffic(input int count);
      wr_target += count;
      rd_target += count;
      while (wr_acc < wr_target || rd_acc < rd_target)
         step();
   endtask

   // ----------------------------------------------------------
   // test sequence
   // ----------------------------------------------------------
   initial begin
      errors = 0;
      wr_target = 0;
      rd_target = 0;
      aw_sent = 0;
      w_sent = 0;
      ar_sent = 0;
      wr_acc = 0;
      rd_acc = 0;
      b_pend = 0;
      b_count = 0;
      r_count = 0;
      pop_count = 0;
      model_drops = 0;
      aw_fire = 1'b0;
      w_fire = 1'b0;
      ar_fire = 1'b0;
      for (int i = 0; i < REG_COUNT; i++)
         model_regs[i] = '0;
      sync_rst_n = 1'b0;
      s_awaddr = '0;
      s_awvalid = 1'b0;
      s_wdata = '0;
      s_wstrb = '0;
      s_wvalid = 1'b0;
      s_bready = 1'b0;
      s_araddr = '0;
      s_arvalid = 1'b0;
      s_rready = 1'b0;
      log_pop = 1'b0;
      void'($urandom(32'h42c5));
      repeat (3) @(posedge clk);
      sync_rst_n <= 1'b1;

      // mixed reads and writes with random back-pressure
      set_mode(50, 70, 70, 60);
      run_traffic(WR_MIXED);
      // rare ready, requests stall for many cycles
      set_mode(60, 5, 5, 50);
      run_traffic(WR_STALL);
      // no pops, log overflows
      set_mode(80, 100, 100, 0);
      run_traffic(WR_FLOOD);
      while (pipeline_busy())
         step();
      check_equal(model_drops != 0, 1'b1, "records dropped in overflow phase");
      // drain responses and the log
      set_mode(0, 100, 100, 100);
      while (b_pend != 0 || exp_rdata.size() != 0 || fifo_hdr.size() != 0 || pipeline_busy())
         step();
      step();
      @(negedge clk);

      check_equal(b_count, wr_acc, "write response count");
      check_equal(r_count, rd_acc, "read response count");
      check_equal(drop_count, model_drops, "final drop_count");
      check_equal(log_valid, 1'b0, "log empty at end");
      $display("%0d errors, %0d writes, %0d reads, %0d records popped, %0d dropped",
               errors, wr_acc, rd_acc, pop_count, model_drops);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   // watchdog, 40 cycles per transaction
   initial begin
      #(TX_COUNT * 40 * CLK_PERIOD);
      $display("timeout: run did not finish within %0d ns", TX_COUNT * 40 * CLK_PERIOD);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

/* verilog.f */
design/rr_pkg.sv
design/axil_record_mstr.sv
design/rr_log_fifo.sv
design/axil_reg_slave.sv
design/rr_subsys_top.sv
testbench/tb_top.sv
